// File: Makefile
TOP = fc_layer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "FAIL: run did not finish"; exit 1; fi
	@echo "PASS"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: fc_input.txt
0 4
0003fffe 00020005 ffff0004
fff60007 0003fffd 00020001
0100ff00 00100010 fff00002
00000001 12340064 00058000
00000fe8 fffff045 ffffefe9 ffff7dff
0 3
80007fff 80007fff 7fff8000
80007fff 80007fff 7fff8000
80007fff 80007fff 7fffffff
c0000000 bffd0003 40018000 80008001
0 1
0005fffd fff90004 0002ffff
ffffffdd fffffff4 0000000a 00000003
1 4096
54d55800 00fff000 ff800800 ff001000
0 1
7fff0001 7fffffff 80000000
3fff0001 ffffffff c0008000 00000000
0 6
00010001 00010002 00030004
0002ffff 00050006 fff90008
fffe0003 0004fffb 00060000
00000000 11112222 33334444
00640032 0064ffce ff9c0032
ffffffff ffff0001 0001ffff
00002714 fffff628 ffffd8d8 000009c1

// File: fc_layer_sva.sv
`timescale 1ns/100ps

module fc_layer_sva (
	input logic               clk,
	input logic               reset_n,
	input logic               i_run,
	input logic               i_idle,
	input logic               i_read,
	input logic               i_done,
	input logic               i_mem_ce,
	input fc_pkg::seq_state_t i_wr_state
);
	import fc_pkg::*;

	// Done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		i_done |=> !i_done)
		else $error("o_done stayed high for more than one cycle");

	// No new run request lands in the read phase
	a_run_in_read: assert property (@(posedge clk) disable iff (!reset_n)
		!(i_read && i_run && !i_idle))
		else $error("i_run seen while the read side was busy");

	// Done comes straight from the write run once the reads have stopped
	a_done_state: assert property (@(posedge clk) disable iff (!reset_n)
		i_done |-> !i_read && $past(i_wr_state == SEQ_RUN))
		else $error("o_done high without a finished read side and write run");

	// Memory enable opens only on the cycle after an accepted start
	a_ce_on_start: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(i_mem_ce) |-> $past(i_run && i_idle))
		else $error("o_mem_ce rose without an accepted run");

endmodule

// File: fc_layer_tb.sv
`timescale 1ns/100ps

module fc_layer_tb;
	import fc_pkg::*;

	logic  clk;
	logic  reset_n;
	logic  run;
	cnt_t  num_cnt;
	logic  idle;
	logic  read;
	logic  write;
	logic  done;
	addr_t mem_addr;
	logic  mem_ce;
	word_t node_q = '0;
	word_t wgt0_q = '0;
	word_t wgt1_q = '0;
	acc_t  result_0;
	acc_t  result_1;
	acc_t  result_2;
	acc_t  result_3;

	// Memory models, one word per address
	word_t node_mem [0:4095];
	word_t wgt0_mem [0:4095];
	word_t wgt1_mem [0:4095];

	acc_t        exp_res [4];
	logic [31:0] lfsr_state = 32'haa3f_ddf0;
	int          fd;

	fc_tb_clock u_clock (
		.clk     (clk),
		.reset_n (reset_n)
	);

	fc_layer_top UUT (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_run      (run),
		.i_num_cnt  (num_cnt),
		.o_idle     (idle),
		.o_read     (read),
		.o_write    (write),
		.o_done     (done),
		.o_mem_addr (mem_addr),
		.o_mem_ce   (mem_ce),
		.i_node_q   (node_q),
		.i_wgt0_q   (wgt0_q),
		.i_wgt1_q   (wgt1_q),
		.o_result_0 (result_0),
		.o_result_1 (result_1),
		.o_result_2 (result_2),
		.o_result_3 (result_3)
	);

	bind fc_sequencer fc_layer_sva u_sva (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_run      (i_run),
		.i_idle     (o_idle),
		.i_read     (o_read),
		.i_done     (o_done),
		.i_mem_ce   (o_mem_ce),
		.i_wr_state (wr_state)
	);

	// Synchronous read, data one cycle after ce
	always @(posedge clk) begin
		if (mem_ce) begin
			node_q <= node_mem[mem_addr];
			wgt0_q <= wgt0_mem[mem_addr];
			wgt1_q <= wgt1_mem[mem_addr];
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_random_bits(input int nbits, output int value);
		value = 0;
		for (int i = 0; i < nbits; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic stop_on_failure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_acc(input string name, input acc_t got, input acc_t exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_results();
		check_acc("o_result_0", result_0, exp_res[0]);
		check_acc("o_result_1", result_1, exp_res[1]);
		check_acc("o_result_2", result_2, exp_res[2]);
		check_acc("o_result_3", result_3, exp_res[3]);
	endtask

	// Mode 0 lists N lines of words, mode 1 derives them from the address
	task automatic load_case(input int mode, input int n);
		int    code;
		word_t w_node;
		word_t w_wgt0;
		word_t w_wgt1;
		word_t e0;
		word_t e1;
		word_t e2;
		word_t e3;
		for (int a = 0; a < n; a++) begin
			if (mode == 1) begin
				node_mem[a] = {lane_t'(a), lane_t'(2)};
				wgt0_mem[a] = {lane_t'(a), lane_t'(a)};
				wgt1_mem[a] = {lane_t'(-1), lane_t'(-a)};
			end else begin
				code = $fscanf(fd, "%h %h %h", w_node, w_wgt0, w_wgt1);
				if (code != 3) begin
					$display("Malformed memory line in fc_input.txt");
					stop_on_failure();
				end
				node_mem[a] = w_node;
				wgt0_mem[a] = w_wgt0;
				wgt1_mem[a] = w_wgt1;
			end
		end
		code = $fscanf(fd, "%h %h %h %h", e0, e1, e2, e3);
		if (code != 4) begin
			$display("Malformed expected-result line in fc_input.txt");
			stop_on_failure();
		end
		exp_res[0] = acc_t'(e0);
		exp_res[1] = acc_t'(e1);
		exp_res[2] = acc_t'(e2);
		exp_res[3] = acc_t'(e3);
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		@(negedge clk);
		while (idle !== 1'b1 && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (idle !== 1'b1) begin
			$display("Timeout: engine never returned to idle");
			stop_on_failure();
		end
	endtask

	// Cycle k is sampled at the falling edge after edge k-1
	task automatic run_case(input int n);
		int   cyc;
		logic done_seen;
		cyc = 0;
		done_seen = 1'b0;
		@(posedge clk);
		run <= 1'b1;
		num_cnt <= cnt_t'(n);
		while (!done_seen && cyc < n + 20) begin
			@(posedge clk);
			// Stray request once the read side has finished
			run <= (cyc == n + 1);
			num_cnt <= (cyc == n + 1) ? cnt_t'(13) : cnt_t'(n);
			@(negedge clk);
			cyc++;
			check_bit("o_read", read, cyc <= n);
			check_bit("o_mem_ce", mem_ce, cyc <= n);
			if (cyc <= n) begin
				check_addr("o_mem_addr", mem_addr, addr_t'(cyc - 1));
			end
			check_bit("o_write", write, cyc <= n + 3);
			check_bit("o_idle", idle, 1'b0);
			check_bit("o_done", done, cyc == n + 4);
			if (done === 1'b1) begin
				done_seen = 1'b1;
				check_results();
			end
		end
		if (!done_seen) begin
			$display("Timeout: o_done never pulsed for a run of %0d words", n);
			stop_on_failure();
		end
		@(negedge clk);
		check_bit("o_done", done, 1'b0);
		check_bit("o_idle", idle, 1'b1);
		// Sums are held after the run
		check_results();
	endtask

	initial begin
		int code;
		int mode;
		int n;
		int gap;
		int case_cnt;
		int t;
		run <= 1'b0;
		num_cnt <= '0;
		case_cnt = 0;
		t = 0;
		while (reset_n !== 1'b1 && t < 20) begin
			@(posedge clk);
			t++;
		end
		if (reset_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			stop_on_failure();
		end
		@(negedge clk);
		check_bit("o_idle", idle, 1'b1);
		check_bit("o_read", read, 1'b0);
		check_bit("o_write", write, 1'b0);
		check_bit("o_done", done, 1'b0);
		check_bit("o_mem_ce", mem_ce, 1'b0);
		exp_res = '{default: '0};
		check_results();

		fd = $fopen("fc_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open fc_input.txt");
			stop_on_failure();
		end
		code = $fscanf(fd, "%d %d", mode, n);
		while (code == 2 && case_cnt < 64) begin
			if (n < 1 || n > 4096) begin
				$display("Word count %0d out of range in fc_input.txt", n);
				stop_on_failure();
			end
			load_case(mode, n);
			take_random_bits(3, gap);
			repeat (gap) @(posedge clk);
			wait_idle();
			run_case(n);
			case_cnt++;
			code = $fscanf(fd, "%d %d", mode, n);
		end
		$fclose(fd);
		if (case_cnt == 0) begin
			$display("No test cases found in fc_input.txt");
			stop_on_failure();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// File: fc_layer_top.sv
`timescale 1ns/100ps

module fc_layer_top (
	input  logic          clk,
	input  logic          reset_n,
	input  logic          i_run,
	input  fc_pkg::cnt_t  i_num_cnt,
	output logic          o_idle,
	output logic          o_read,
	output logic          o_write,
	output logic          o_done,
	// Shared by the node memory and both weight memories
	output fc_pkg::addr_t o_mem_addr,
	output logic          o_mem_ce,
	input  fc_pkg::word_t i_node_q,
	input  fc_pkg::word_t i_wgt0_q,
	input  fc_pkg::word_t i_wgt1_q,
	output fc_pkg::acc_t  o_result_0,
	output fc_pkg::acc_t  o_result_1,
	output fc_pkg::acc_t  o_result_2,
	output fc_pkg::acc_t  o_result_3
);
	import fc_pkg::*;

	word_t                wgt_q [NUM_WEIGHT_MEMS];
	acc_t                 lane_result [NUM_LANES];
	logic [NUM_LANES-1:0] lane_valid;
	logic                 rd_valid;
	logic                 lane_start;
	logic                 all_valid;

	assign wgt_q[0] = i_wgt0_q;
	assign wgt_q[1] = i_wgt1_q;

	// Lanes clear only on an accepted start
	assign lane_start = i_run & o_idle;

	// Write counter steps when every lane has a sum ready
	assign all_valid = &lane_valid;

	fc_sequencer u_seq (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_run         (i_run),
		.i_num_cnt     (i_num_cnt),
		.i_lanes_valid (all_valid),
		.o_idle        (o_idle),
		.o_read        (o_read),
		.o_write       (o_write),
		.o_done        (o_done),
		.o_rd_valid    (rd_valid),
		.o_mem_ce      (o_mem_ce),
		.o_mem_addr    (o_mem_addr)
	);

	// Lane 2k takes the high halves, lane 2k+1 the low halves of weight k
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		lane_t node_op;
		lane_t wgt_op;

		assign node_op = i_node_q[LANE_W*(2 - g%2) - 1 -: LANE_W];
		assign wgt_op  = wgt_q[g/2][LANE_W*(2 - g%2) - 1 -: LANE_W];

		fc_mac_lane u_lane (
			.clk      (clk),
			.reset_n  (reset_n),
			.i_run    (lane_start),
			.i_valid  (rd_valid),
			.i_node   (node_op),
			.i_wgt    (wgt_op),
			.o_result (lane_result[g]),
			.o_valid  (lane_valid[g])
		);
	end

	assign o_result_0 = lane_result[0];
	assign o_result_1 = lane_result[1];
	assign o_result_2 = lane_result[2];
	assign o_result_3 = lane_result[3];

endmodule

// File: fc_mac_lane.sv
`timescale 1ns/100ps

module fc_mac_lane (
	input  logic          clk,
	input  logic          reset_n,
	input  logic          i_run,
	input  logic          i_valid,
	input  fc_pkg::lane_t i_node,
	input  fc_pkg::lane_t i_wgt,
	output fc_pkg::acc_t  o_result,
	output logic          o_valid
);
	import fc_pkg::*;

	// Bit 0 marks a filled product register
	logic [MAC_LATENCY-1:0] vld_pipe;
	acc_t                   prod;
	acc_t                   acc;

	// Stage one, full 32-bit signed product
	always_ff @(posedge clk) begin
		if (i_valid) begin
			prod <= acc_t'(i_node) * acc_t'(i_wgt);
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			vld_pipe <= '0;
		end else if (i_run) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[MAC_LATENCY-2:0], i_valid};
		end
	end

	// Stage two, running sum wraps at 32 bits
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			acc <= '0;
		end else if (i_run) begin
			acc <= '0;
		end else if (vld_pipe[0]) begin
			acc <= acc + prod;
		end
	end

	// Sum is held after the last item until the next run
	assign o_result = acc;
	assign o_valid  = vld_pipe[MAC_LATENCY-1];

endmodule

// File: fc_pkg.sv
package fc_pkg;

	// Memory word and lane widths
	localparam int DATA_W = 32;
	localparam int LANE_W = 16;

	// Shared read address, 4096 words deep
	localparam int ADDR_W = 12;

	// Two weight memories, each feeding a high and a low lane
	localparam int NUM_WEIGHT_MEMS = 2;
	localparam int NUM_LANES       = 2 * NUM_WEIGHT_MEMS;

	// Lane valid in to lane valid out
	localparam int MAC_LATENCY = 2;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic signed [LANE_W-1:0] lane_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// One extra bit so that a full 4096-word run fits
	typedef logic [ADDR_W:0] cnt_t;

	// Dot-product result, wraps modulo 2**32
	typedef logic signed [DATA_W-1:0] acc_t;

	// Shared by the read and the write state machines
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'b00,
		SEQ_RUN  = 2'b01,
		SEQ_DONE = 2'b10
	} seq_state_t;

endpackage

// File: fc_sequencer.sv
`timescale 1ns/100ps

module fc_sequencer (
	input  logic          clk,
	input  logic          reset_n,
	input  logic          i_run,
	input  fc_pkg::cnt_t  i_num_cnt,
	input  logic          i_lanes_valid,
	output logic          o_idle,
	output logic          o_read,
	output logic          o_write,
	output logic          o_done,
	output logic          o_rd_valid,
	output logic          o_mem_ce,
	output fc_pkg::addr_t o_mem_addr
);
	import fc_pkg::*;

	seq_state_t rd_state;
	seq_state_t rd_state_nxt;
	seq_state_t wr_state;
	seq_state_t wr_state_nxt;
	cnt_t       num_cnt;
	addr_t      last_addr;
	addr_t      rd_cnt;
	addr_t      wr_cnt;
	logic       start;
	logic       rd_last;
	logic       wr_last;
	logic       rd_valid;

	// A run is only accepted when both machines are idle
	assign o_idle = (rd_state == SEQ_IDLE) && (wr_state == SEQ_IDLE);
	assign start  = i_run && o_idle;

	assign o_read  = (rd_state == SEQ_RUN);
	assign o_write = (wr_state == SEQ_RUN);
	// Write side trails the read side, so done comes from it
	assign o_done  = (wr_state == SEQ_DONE);

	// State registers
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_state <= SEQ_IDLE;
			wr_state <= SEQ_IDLE;
		end else begin
			rd_state <= rd_state_nxt;
			wr_state <= wr_state_nxt;
		end
	end

	// Read side next state
	always_comb begin
		rd_state_nxt = rd_state;
		case (rd_state)
			SEQ_IDLE: begin
				if (start) begin
					rd_state_nxt = SEQ_RUN;
				end
			end
			SEQ_RUN: begin
				if (rd_last) begin
					rd_state_nxt = SEQ_DONE;
				end
			end
			SEQ_DONE: begin
				rd_state_nxt = SEQ_IDLE;
			end
			default: begin
				rd_state_nxt = SEQ_IDLE;
			end
		endcase
	end

	// Write side next state
	always_comb begin
		wr_state_nxt = wr_state;
		case (wr_state)
			SEQ_IDLE: begin
				if (start) begin
					wr_state_nxt = SEQ_RUN;
				end
			end
			SEQ_RUN: begin
				if (wr_last) begin
					wr_state_nxt = SEQ_DONE;
				end
			end
			SEQ_DONE: begin
				wr_state_nxt = SEQ_IDLE;
			end
			default: begin
				wr_state_nxt = SEQ_IDLE;
			end
		endcase
	end

	// Capture the run length with the start
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			num_cnt <= '0;
		end else if (start) begin
			num_cnt <= i_num_cnt;
		end
	end

	// N of 4096 gives a last index of 4095, which still fits
	assign last_addr = addr_t'(num_cnt - cnt_t'(1));

	assign rd_last = o_read && (rd_cnt == last_addr);
	assign wr_last = o_write && i_lanes_valid && (wr_cnt == last_addr);

	// Read address, shared by node and weight memories
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_cnt <= '0;
		end else if (rd_last) begin
			rd_cnt <= '0;
		end else if (o_read) begin
			rd_cnt <= rd_cnt + addr_t'(1);
		end
	end

	// Counts cycles in which every lane has a valid sum
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_cnt <= '0;
		end else if (wr_last) begin
			wr_cnt <= '0;
		end else if (o_write && i_lanes_valid) begin
			wr_cnt <= wr_cnt + addr_t'(1);
		end
	end

	// Memory data shows up one cycle after ce
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= o_read;
		end
	end

	assign o_rd_valid = rd_valid;
	assign o_mem_ce   = o_read;
	assign o_mem_addr = rd_cnt;

endmodule

// File: fc_tb_clock.sv
`timescale 1ns/100ps

module fc_tb_clock (
	output logic clk,
	output logic reset_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held low for the first 5 cycles
	initial begin
		reset_n = 1'b0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

// File: sources.f
fc_pkg.sv
fc_mac_lane.sv
fc_sequencer.sv
fc_layer_top.sv
fc_layer_sva.sv
fc_tb_clock.sv
fc_layer_tb.sv
